// File: sim.f
+incdir+common
common/arb_pkg.sv
common/arb_if.sv
arbiter/arbiter4.sv
source/out_buffer.sv
source/arb_collect_top.sv
bench/tb_arb_collect.sv

// File: bench/tb_arb_collect.sv
`include "arb_params.svh"

module tb_arb_collect;

	localparam int ROWS = 14;

	typedef struct packed {
		logic [3:0] mask;    // Clients that raise a new request
		logic [7:0] hold;    // Cycles spent on this row
		logic       pop;     // Pop strobe during the row
	} row_t;

	logic              clk = 1'b0;
	logic              rst_n_i;
	arb_pkg::req_vec_t request_i;
	arb_pkg::data_t    data0_i;
	arb_pkg::data_t    data1_i;
	arb_pkg::data_t    data2_i;
	arb_pkg::data_t    data3_i;
	logic              pop_i;
	arb_pkg::req_vec_t grant_o;
	logic              grant_v_o;
	arb_pkg::data_t    out_data_o;
	logic              out_valid_o;

	// Reference state
	arb_pkg::req_vec_t req_mask;
	arb_pkg::data_t    client_data [4];
	arb_pkg::req_vec_t set_q [$];      // Oldest pending set first
	arb_pkg::data_t    fifo_q [$];

	always #50 clk = ~clk;

	arb_collect_top arb_collect_top_inst (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.request_i   (request_i),
		.data0_i     (data0_i),
		.data1_i     (data1_i),
		.data2_i     (data2_i),
		.data3_i     (data3_i),
		.pop_i       (pop_i),
		.grant_o     (grant_o),
		.grant_v_o   (grant_v_o),
		.out_data_o  (out_data_o),
		.out_valid_o (out_valid_o)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus table
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic row_t table_row(input int idx);
		case (idx)
			0:  table_row = {4'b0000, 8'd2, 1'b1};   // Idle, pop on empty
			1:  table_row = {4'b0001, 8'd3, 1'b1};   // Single request
			2:  table_row = {4'b1011, 8'd5, 1'b1};   // One set of three
			3:  table_row = {4'b0111, 8'd1, 1'b1};
			4:  table_row = {4'b1001, 8'd1, 1'b1};   // Arrives behind set {1,2}
			5:  table_row = {4'b0000, 8'd5, 1'b1};
			6:  table_row = {4'b1111, 8'd1, 1'b0};   // Fill the FIFO
			7:  table_row = {4'b0001, 8'd6, 1'b0};
			8:  table_row = {4'b1010, 8'd2, 1'b0};   // Held while full
			9:  table_row = {4'b0000, 8'd8, 1'b1};
			10: table_row = {4'b0101, 8'd1, 1'b1};
			11: table_row = {4'b1010, 8'd1, 1'b0};
			12: table_row = {4'b0110, 8'd2, 1'b1};
			13: table_row = {4'b0000, 8'd6, 1'b1};
			default: table_row = '0;
		endcase
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("ERR %0t: %s expected %0h got %0h", $time, what, expected, actual);
			$display("Test failures found");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// Lowest waiting client of a set
	function automatic arb_pkg::req_vec_t lowest_request(input arb_pkg::req_vec_t set);
		arb_pkg::req_vec_t found;
		found = '0;
		for (int i = 3; i >= 0; i--) begin
			if (set[i]) begin
				found = '0;
				found[i] = 1'b1;
			end
		end
		return found;
	endfunction

	task automatic raise_requests(input arb_pkg::req_vec_t mask);
		for (int i = 0; i < 4; i++) begin
			if (mask[i] && !req_mask[i]) begin
				req_mask[i] = 1'b1;
				client_data[i] = arb_pkg::data_t'($urandom());   // Fresh word per request
			end
		end
	endtask

	task automatic drive_inputs(input logic pop_en);
		request_i <= req_mask;
		data0_i   <= client_data[0];
		data1_i   <= client_data[1];
		data2_i   <= client_data[2];
		data3_i   <= client_data[3];
		pop_i     <= pop_en;
	endtask

	// Predict this cycle's outputs, compare, then advance to the next edge
	task automatic check_cycle();
		arb_pkg::req_vec_t head;
		arb_pkg::req_vec_t exp_grant;
		arb_pkg::req_vec_t queued;
		arb_pkg::req_vec_t arrivals;
		logic              exp_gv;
		logic              full;
		queued = '0;
		foreach (set_q[i]) begin
			queued = queued | set_q[i];
		end
		full = (fifo_q.size() == `ARB_FIFO_DEPTH);
		head = (set_q.size() == 0) ? request_i : set_q[0];
		exp_gv = !full && (head != '0);
		exp_grant = exp_gv ? lowest_request(head) : '0;

		check_value(grant_o, exp_grant, "grant_o");
		check_value(grant_v_o, exp_gv, "grant_v_o");
		check_value(out_valid_o, fifo_q.size() != 0, "out_valid_o");
		if (fifo_q.size() != 0) begin
			check_value(out_data_o, fifo_q[0], "out_data_o");
		end

		if (pop_i && fifo_q.size() != 0) begin
			void'(fifo_q.pop_front());
		end
		if (exp_gv) begin
			for (int i = 0; i < 4; i++) begin
				if (exp_grant[i]) begin
					fifo_q.push_back(client_data[i]);
					req_mask[i] = 1'b0;   // Client drops after its grant
				end
			end
			if (set_q.size() == 0) begin
				arrivals = request_i & ~exp_grant;
			end else begin
				set_q[0] = set_q[0] & ~exp_grant;
				if (set_q[0] == '0) begin
					void'(set_q.pop_front());
				end
				arrivals = request_i & ~queued & ~exp_grant;
			end
			if (arrivals != '0) begin
				set_q.push_back(arrivals);
			end
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Main sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin : main_seq
		row_t row;
		void'($urandom(6833));
		rst_n_i = 1'b0;
		request_i = '0;
		data0_i = '0;
		data1_i = '0;
		data2_i = '0;
		data3_i = '0;
		pop_i = 1'b0;
		req_mask = '0;
		for (int i = 0; i < 4; i++) begin
			client_data[i] = '0;
		end

		repeat (10) @(posedge clk);
		@(negedge clk);
		check_value(grant_o, 4'b0000, "grant_o in reset");
		check_value(grant_v_o, 1'b0, "grant_v_o in reset");
		check_value(out_valid_o, 1'b0, "out_valid_o in reset");
		@(posedge clk);
		rst_n_i <= 1'b1;

		for (int r = 0; r < ROWS; r++) begin
			row = table_row(r);
			for (int c = 0; c < row.hold; c++) begin
				@(posedge clk);
				if (c == 0) begin
					raise_requests(row.mask);
				end
				drive_inputs(row.pop);
				@(negedge clk);
				check_cycle();
			end
		end

		// Serve what is left and empty the FIFO
		while (req_mask != '0 || fifo_q.size() != 0) begin
			@(posedge clk);
			drive_inputs(1'b1);
			@(negedge clk);
			check_cycle();
		end

		$display("All tests passed!");
		$finish;
	end

	// Bounded by the table length
	initial begin : watchdog
		int   max_hold;
		row_t row;
		max_hold = 0;
		for (int r = 0; r < ROWS; r++) begin
			row = table_row(r);
			if (row.hold > max_hold) begin
				max_hold = row.hold;
			end
		end
		#(ROWS * max_hold * 100);
		$display("Timeout: the test did not finish in time");
		$display("Test failures found");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: source/arb_collect_top.sv
module arb_collect_top (
	input  logic              clk,
	input  logic              rst_n_i,
	input  arb_pkg::req_vec_t request_i,
	input  arb_pkg::data_t    data0_i,
	input  arb_pkg::data_t    data1_i,
	input  arb_pkg::data_t    data2_i,
	input  arb_pkg::data_t    data3_i,
	input  logic              pop_i,
	output arb_pkg::req_vec_t grant_o,
	output logic              grant_v_o,
	output arb_pkg::data_t    out_data_o,
	output logic              out_valid_o
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Arbiter to buffer link
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	arb_if arb_bus ();

	assign arb_bus.request = request_i;
	assign grant_o         = arb_bus.grant;     // Doubles as the client acknowledge
	assign grant_v_o       = arb_bus.grant_v;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Blocks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	arbiter4 arbiter4_inst (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.arb     (arb_bus.arbiter)
	);

	out_buffer out_buffer_inst (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.arb         (arb_bus.buffer),
		.data0_i     (data0_i),
		.data1_i     (data1_i),
		.data2_i     (data2_i),
		.data3_i     (data3_i),
		.pop_i       (pop_i),
		.out_data_o  (out_data_o),
		.out_valid_o (out_valid_o)
	);

endmodule

// File: source/out_buffer.sv
`include "arb_params.svh"

module out_buffer (
	input  logic           clk,
	input  logic           rst_n_i,
	arb_if.buffer          arb,
	input  arb_pkg::data_t data0_i,
	input  arb_pkg::data_t data1_i,
	input  arb_pkg::data_t data2_i,
	input  arb_pkg::data_t data3_i,
	input  logic           pop_i,
	output arb_pkg::data_t out_data_o,
	output logic           out_valid_o
);

	localparam int PTR_W = $clog2(`ARB_FIFO_DEPTH);

	typedef logic [PTR_W-1:0] ptr_t;

	arb_pkg::data_t     mem [`ARB_FIFO_DEPTH];
	arb_pkg::data_t     wr_data;
	ptr_t               wr_ptr_q;
	ptr_t               rd_ptr_q;
	arb_pkg::fifo_cnt_t count_q;
	logic               wr_en;
	logic               rd_en;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Word select
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		case (arb.grant)
			4'b0001: wr_data = data0_i;
			4'b0010: wr_data = data1_i;
			4'b0100: wr_data = data2_i;
			4'b1000: wr_data = data3_i;
			default: wr_data = '0;     // No grant this cycle
		endcase
	end

	assign wr_en = arb.grant_v;
	assign rd_en = pop_i && (count_q != '0);   // Pop on empty is dropped

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// FIFO storage and pointers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr_q] <= wr_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr_q <= wr_ptr_q + ptr_t'(1);   // Wraps at depth
			end
			if (rd_en) begin
				rd_ptr_q <= rd_ptr_q + ptr_t'(1);
			end

			if (wr_en && !rd_en) begin
				count_q <= count_q + 1'b1;
			end else if (rd_en && !wr_en) begin
				count_q <= count_q - 1'b1;
			end
		end
	end

	// Read side sees a word only after its write edge
	assign out_data_o  = mem[rd_ptr_q];
	assign out_valid_o = (count_q != '0);

	assign arb.buffer_full = (count_q == arb_pkg::fifo_cnt_t'(`ARB_FIFO_DEPTH));

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// The arbiter must honour back-pressure
	ap_no_write_full: assert property (@(posedge clk) disable iff (!rst_n_i)
		arb.buffer_full |-> !arb.grant_v)
		else $error("out_buffer: write while full");

endmodule

// File: arbiter/arbiter4.sv
`include "arb_params.svh"

module arbiter4 (
	input  logic   clk,
	input  logic   rst_n_i,
	arb_if.arbiter arb
);

	arb_pkg::req_vec_t  sets_q [`ARB_SETS];   // Oldest set at index 0
	arb_pkg::req_vec_t  sets_n [`ARB_SETS];
	arb_pkg::tail_t     tail_q;
	arb_pkg::tail_t     tail_n;
	arb_pkg::arb_state_t state;

	arb_pkg::req_vec_t  pending;     // Union of all queued sets
	arb_pkg::req_vec_t  head;        // Set the grant is taken from
	arb_pkg::req_vec_t  grant_c;     // Lowest bit of head
	arb_pkg::req_vec_t  head_rest;   // Set 0 after the grant
	arb_pkg::req_vec_t  arrivals;    // Requests not yet queued
	logic               grant_v_c;
	logic               set_overflow;   // Arrivals with no free set register

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Grant selection
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		pending = '0;
		for (int i = 0; i < `ARB_SETS; i++) begin
			pending = pending | sets_q[i];
		end
	end

	assign state = (tail_q == '0) ? arb_pkg::ARB_IDLE : arb_pkg::ARB_QUEUED;

	// Idle means the incoming request is itself the working set
	assign head      = (state == arb_pkg::ARB_IDLE) ? arb.request : sets_q[0];
	assign grant_c   = head & (~head + 4'd1);    // Isolate lowest set bit
	assign grant_v_c = !arb.buffer_full && (head != '0);

	assign arb.grant_v = grant_v_c;
	assign arb.grant   = grant_v_c ? grant_c : '0;

	assign head_rest = sets_q[0] & ~grant_c;
	assign arrivals  = arb.request & ~pending & ~grant_c;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Set queue update
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		sets_n = sets_q;
		tail_n = tail_q;
		set_overflow = 1'b0;

		if (grant_v_c) begin
			if (state == arb_pkg::ARB_QUEUED) begin
				if (head_rest == '0) begin
					// Oldest set is used up, move the rest forward
					for (int i = 0; i < `ARB_SETS - 1; i++) begin
						sets_n[i] = sets_q[i+1];
					end
					sets_n[`ARB_SETS-1] = '0;
					tail_n = tail_q - 2'd1;
				end else begin
					sets_n[0] = head_rest;
				end
			end

			// New arrivals go behind every older set
			if (arrivals != '0) begin
				if (tail_n < `ARB_SETS) begin
					sets_n[tail_n] = arrivals;
					tail_n = tail_n + 2'd1;
				end else begin
					set_overflow = 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			tail_q <= '0;
			for (int i = 0; i < `ARB_SETS; i++) begin
				sets_q[i] <= '0;
			end
		end else begin
			tail_q <= tail_n;
			sets_q <= sets_n;     // Holds while the FIFO is full
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Tail never needs a fourth set and agrees with what is queued
	ap_tail_range: assert property (@(posedge clk) disable iff (!rst_n_i)
		!set_overflow &&
		((state == arb_pkg::ARB_IDLE) == (pending == '0)))
		else $error("arbiter4: tail count out of step with pending sets");

	// One client at a time, and only one that is asking
	ap_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
		arb.grant_v |-> ($onehot(arb.grant) && ((arb.grant & arb.request) == arb.grant)))
		else $error("arbiter4: grant not one-hot");

	// Whatever waits this cycle and is not granted is still queued next cycle
	ap_pending_kept: assert property (@(posedge clk) disable iff (!rst_n_i)
		((pending & ~arb.grant) != '0) |=>
		((pending & $past(pending & ~arb.grant)) == $past(pending & ~arb.grant)))
		else $error("arbiter4: pending request lost without a grant");

endmodule

// File: common/arb_if.sv
interface arb_if;

	arb_pkg::req_vec_t request;       // Client request levels
	arb_pkg::req_vec_t grant;         // One-hot grant pulse
	logic              grant_v;       // Grant valid, also the FIFO write
	logic              buffer_full;   // Back-pressure from the FIFO

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Views of the two ends
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	modport arbiter (
		input  request,
		input  buffer_full,
		output grant,
		output grant_v
	);

	modport buffer (
		input  grant,
		input  grant_v,
		output buffer_full
	);

endinterface

// File: common/arb_pkg.sv
`include "arb_params.svh"

package arb_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Vector types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [3:0] req_vec_t;                    // One bit per client
	typedef logic [`ARB_DATA_W-1:0] data_t;           // Client data word
	typedef logic [1:0] tail_t;                       // Valid pending sets, 0 to 3
	typedef logic [$clog2(`ARB_FIFO_DEPTH+1)-1:0] fifo_cnt_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Arbiter state, derived from the tail count
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic {
		ARB_IDLE,    // No set pending
		ARB_QUEUED   // At least one set pending
	} arb_state_t;

endpackage

// File: common/arb_params.svh
`ifndef ARB_PARAMS_SVH
`define ARB_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Request collector sizes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Bits in one client data word
`define ARB_DATA_W 8

// Output FIFO entries, keep a power of two
`define ARB_FIFO_DEPTH 4

// Pending set registers in the arbiter
// Four disjoint non-empty sets minus the granted one leave room for three
`define ARB_SETS 3

`endif
